// ==== design/aes_consts.svh ====
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// ****************************************
// cipher geometry
// ****************************************
`define AES_BLOCK_BITS 128
`define AES_KEY_BITS 192
`define AES_WORD_BITS 32
`define AES_BYTE_BITS 8
// twelve inverse rounds, so thirteen round keys
`define AES_ROUNDS 12

// ****************************************
// transport
// ****************************************
`define TAG_BITS 4
// the sender starts with one credit per input queue slot
`define IN_QUEUE_DEPTH 2
`define OUT_QUEUE_DEPTH 2
`define OUT_CREDITS_INIT 2

`endif

// ==== design/aesPkg.sv ====
`include "aes_consts.svh"

package aesPkg;

        // one full cipher state, byte 0 sits in the top eight bits
        typedef logic [`AES_BLOCK_BITS-1:0] stateT;

        // a single word of the expanded key
        typedef logic [`AES_WORD_BITS-1:0] wordT;

        // round keys held in the order decryption consumes them
        // index 0 is the last key the schedule produces
        typedef stateT [`AES_ROUNDS:0] roundKeysT;

endpackage

// ==== design/linkPkg.sv ====
`include "aes_consts.svh"

package linkPkg;

        typedef logic [`TAG_BITS-1:0] tagT;

        // wide enough to hold the full sink credit allowance
        typedef logic [$clog2(`OUT_CREDITS_INIT + 1)-1:0] creditT;

        typedef struct packed {
                tagT                       tag;
                logic [`AES_KEY_BITS-1:0]   key;
                logic [`AES_BLOCK_BITS-1:0] cipherText;
        } decReqT;

        typedef struct packed {
                tagT                       tag;
                logic [`AES_BLOCK_BITS-1:0] plainText;
        } decRspT;

endpackage

// ==== design/byteSubst.sv ====
`include "aes_consts.svh"

module byteSubst #(
        parameter bit Inverse = 1'b0,
        parameter int Lanes = 4
) (
        input  logic [Lanes-1:0][`AES_BYTE_BITS-1:0] in,
        output logic [Lanes-1:0][`AES_BYTE_BITS-1:0] out
);

        // ****************************************
        // substitution tables, one row of sixteen per literal
        // ****************************************
        localparam logic [0:255][`AES_BYTE_BITS-1:0] FwdTable = {
                128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
                128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
                128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
                128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
                128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
                128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
                128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
                128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
        };

        localparam logic [0:255][`AES_BYTE_BITS-1:0] InvTable = {
                128'h52096ad53036a538bf40a39e81f3d7fb, 128'h7ce339829b2fff87348e4344c4dee9cb,
                128'h547b9432a6c2233dee4c950b42fac34e, 128'h082ea16628d924b2765ba2496d8bd125,
                128'h72f8f66486689816d4a45ccc5d65b692, 128'h6c704850fdedb9da5e154657a78d9d84,
                128'h90d8ab008cbcd30af7e45805b8b34506, 128'hd02c1e8fca3f0f02c1afbd0301138a6b,
                128'h3a9111414f67dcea97f2cfcef0b4e673, 128'h96ac7422e7ad3585e2f937e81c75df6e,
                128'h47f11a711d29c5896fb7620eaa18be1b, 128'hfc563e4bc6d279209adbc0fe78cd5af4,
                128'h1fdda8338807c731b11210592780ec5f, 128'h60517fa919b54a0d2de57a9f93c99cef,
                128'ha0e03b4dae2af5b0c8ebbb3c83539961, 128'h172b047eba77d626e169146355210c7d
        };

        // every lane looks up independently
        for (genvar i = 0; i < Lanes; i++)
        begin : gLane
                assign out[i] = Inverse ? InvTable[in[i]] : FwdTable[in[i]];
        end

endmodule

// ==== design/keyExpand192.sv ====
`include "aes_consts.svh"

module keyExpand192 (
        input  logic                     clk,
        input  logic                     rstN,
        input  logic                     load,
        input  logic [`AES_KEY_BITS-1:0] key,
        output aesPkg::roundKeysT        roundKeys
);

        localparam int KeyWords = `AES_KEY_BITS / `AES_WORD_BITS;
        localparam int NumWords = 4 * (`AES_ROUNDS + 1);
        localparam int NumBlocks = (NumWords - 1) / KeyWords;

        aesPkg::wordT w [NumWords];

        // the first six words are the cipher key itself
        for (genvar i = 0; i < KeyWords; i++)
        begin : gKeyWord
                assign w[i] = key[`AES_KEY_BITS - 1 - `AES_WORD_BITS * i -: `AES_WORD_BITS];
        end

        // each block opens with rotate, substitute and round constant,
        // the remaining words of the block chain by plain xor
        for (genvar g = 1; g <= NumBlocks; g++)
        begin : gBlock
                localparam logic [7:0] Rcon = 8'h01 << (g - 1);

                aesPkg::wordT rotated;
                aesPkg::wordT substituted;

                assign rotated = {w[KeyWords * g - 1][23:0], w[KeyWords * g - 1][31:24]};

                byteSubst #(
                        .Inverse(1'b0),
                        .Lanes(4)
                ) i_byteSubst (
                        .in(rotated),
                        .out(substituted)
                );

                assign w[KeyWords * g] = w[KeyWords * (g - 1)] ^ substituted ^ {Rcon, 24'h0};

                for (genvar j = 1; j < KeyWords && KeyWords * g + j < NumWords; j++)
                begin : gWord
                        assign w[KeyWords * g + j] = w[KeyWords * g + j - 1]
                                                     ^ w[KeyWords * (g - 1) + j];
                end
        end

        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        roundKeys <= '0;
                end
                else if (load)
                begin
                        // reverse the round order so decryption walks upward
                        for (int k = 0; k <= `AES_ROUNDS; k++)
                        begin
                                roundKeys[k] <= {w[4 * (`AES_ROUNDS - k)],
                                                 w[4 * (`AES_ROUNDS - k) + 1],
                                                 w[4 * (`AES_ROUNDS - k) + 2],
                                                 w[4 * (`AES_ROUNDS - k) + 3]};
                        end
                end
        end

endmodule

// ==== design/invCipherCore.sv ====
`include "aes_consts.svh"

module invCipherCore (
        input  logic            clk,
        input  logic            rstN,
        input  logic            reqValid,
        input  linkPkg::decReqT req,
        output logic            reqReady,
        output logic            rspValid,
        output linkPkg::decRspT rsp,
        input  logic            rspReady
);

        localparam int Msb = `AES_BLOCK_BITS - 1;
        localparam int CntBits = $clog2(`AES_ROUNDS + 1);

        aesPkg::roundKeysT  roundKeys;
        aesPkg::stateT      state;
        aesPkg::stateT      shifted;
        aesPkg::stateT      substituted;
        aesPkg::stateT      keyed;
        aesPkg::stateT      nextState;
        linkPkg::tagT       tag;
        logic [CntBits-1:0] roundCnt;
        logic               busy;
        logic               done;
        logic               accept;

        // ****************************************
        // round helpers
        // ****************************************
        function automatic logic [7:0] byteAt(input aesPkg::stateT s, input int idx);
                return s[Msb - 8 * idx -: 8];
        endfunction

        function automatic logic [7:0] xtime(input logic [7:0] b);
                return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
        endfunction

        // multiply by a constant below 16 as a sum of doublings
        function automatic logic [7:0] gmul(input logic [7:0] b, input logic [3:0] k);
                logic [7:0] x2;
                logic [7:0] x4;
                logic [7:0] x8;
                x2 = xtime(b);
                x4 = xtime(x2);
                x8 = xtime(x4);
                return (k[0] ? b : 8'h00) ^ (k[1] ? x2 : 8'h00)
                       ^ (k[2] ? x4 : 8'h00) ^ (k[3] ? x8 : 8'h00);
        endfunction

        // row r moves right by r columns
        function automatic aesPkg::stateT invShiftRows(input aesPkg::stateT s);
                aesPkg::stateT r;
                for (int c = 0; c < 4; c++)
                begin
                        for (int row = 0; row < 4; row++)
                        begin
                                r[Msb - 8 * (row + 4 * c) -: 8] =
                                        byteAt(s, row + 4 * ((c - row + 4) % 4));
                        end
                end
                return r;
        endfunction

        function automatic aesPkg::stateT invMixColumns(input aesPkg::stateT s);
                aesPkg::stateT r;
                for (int c = 0; c < 4; c++)
                begin
                        for (int row = 0; row < 4; row++)
                        begin
                                r[Msb - 8 * (row + 4 * c) -: 8] =
                                        gmul(byteAt(s, 4 * c + row), 4'd14)
                                        ^ gmul(byteAt(s, 4 * c + (row + 1) % 4), 4'd11)
                                        ^ gmul(byteAt(s, 4 * c + (row + 2) % 4), 4'd13)
                                        ^ gmul(byteAt(s, 4 * c + (row + 3) % 4), 4'd9);
                        end
                end
                return r;
        endfunction

        // ****************************************
        // datapath
        // ****************************************
        keyExpand192 i_keyExpand192 (
                .clk(clk),
                .rstN(rstN),
                .load(accept),
                .key(req.key),
                .roundKeys(roundKeys)
        );

        assign shifted = invShiftRows(state);

        byteSubst #(
                .Inverse(1'b1),
                .Lanes(16)
        ) i_byteSubst (
                .in(shifted),
                .out(substituted)
        );

        assign keyed = substituted ^ roundKeys[roundCnt];

        // step 0 only adds the first key, the final round skips mixing
        always_comb
        begin
                if (roundCnt == '0)
                begin
                        nextState = state ^ roundKeys[0];
                end
                else if (roundCnt == CntBits'(`AES_ROUNDS))
                begin
                        nextState = keyed;
                end
                else
                begin
                        nextState = invMixColumns(keyed);
                end
        end

        always_ff @(posedge clk)
        begin
                if (accept)
                begin
                        state <= req.cipherText;
                        tag <= req.tag;
                end
                else if (busy)
                begin
                        state <= nextState;
                end
        end

        // ****************************************
        // control
        // ****************************************
        assign accept = reqValid && reqReady;
        assign reqReady = !busy && !done;
        assign rspValid = done;
        assign rsp.tag = tag;
        assign rsp.plainText = state;

        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        busy <= 1'b0;
                        done <= 1'b0;
                        roundCnt <= '0;
                end
                else if (accept)
                begin
                        busy <= 1'b1;
                        roundCnt <= '0;
                end
                else if (busy)
                begin
                        if (roundCnt == CntBits'(`AES_ROUNDS))
                        begin
                                busy <= 1'b0;
                                done <= 1'b1;
                        end
                        else
                        begin
                                roundCnt <= roundCnt + 1'b1;
                        end
                end
                else if (done && rspReady)
                begin
                        done <= 1'b0;
                end
        end

endmodule

// ==== design/creditQueue.sv ====
module creditQueue #(
        parameter type PayloadT = logic,
        parameter int Depth = 2
) (
        input  logic    clk,
        input  logic    rstN,
        input  logic    pushValid,
        input  PayloadT pushData,
        output logic    full,
        input  logic    popReady,
        output logic    popValid,
        output PayloadT popData
);

        localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
        localparam int CountBits = $clog2(Depth + 1);

        PayloadT              mem [Depth];
        logic [PtrBits-1:0]   wrPtr;
        logic [PtrBits-1:0]   rdPtr;
        logic [CountBits-1:0] count;
        logic                 push;
        logic                 pop;

        // pointers wrap at Depth, which need not be a power of two
        function automatic logic [PtrBits-1:0] advance(input logic [PtrBits-1:0] ptr);
                return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
        endfunction

        assign full = count == CountBits'(Depth);
        assign popValid = count != '0;
        assign popData = mem[rdPtr];
        assign push = pushValid && !full;
        assign pop = popValid && popReady;

        always_ff @(posedge clk)
        begin
                if (push)
                begin
                        mem[wrPtr] <= pushData;
                end
        end

        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                        count <= '0;
                end
                else
                begin
                        if (push)
                        begin
                                wrPtr <= advance(wrPtr);
                        end
                        if (pop)
                        begin
                                rdPtr <= advance(rdPtr);
                        end
                        case ({push, pop})
                                2'b10: count <= count + 1'b1;
                                2'b01: count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

endmodule

// ==== design/invCipher192Top.sv ====
`include "aes_consts.svh"

module invCipher192Top (
        input  logic            clk,
        input  logic            rstN,
        input  logic            inValid,
        input  linkPkg::decReqT inReq,
        output logic            inCredit,
        output logic            outValid,
        output linkPkg::decRspT outRsp,
        input  logic            outCredit
);

        linkPkg::decReqT coreReq;
        linkPkg::decRspT coreRsp;
        linkPkg::creditT sinkCredits;
        logic            coreReqValid;
        logic            coreReqReady;
        logic            coreRspValid;
        logic            coreRspReady;
        logic            outFull;
        logic            outPending;
        logic            haveCredit;

        // the sender never overruns this queue because of its credits
        creditQueue #(
                .PayloadT(linkPkg::decReqT),
                .Depth(`IN_QUEUE_DEPTH)
        ) i_inQueue (
                .clk(clk),
                .rstN(rstN),
                .pushValid(inValid),
                .pushData(inReq),
                .full(),
                .popReady(coreReqReady),
                .popValid(coreReqValid),
                .popData(coreReq)
        );

        invCipherCore i_invCipherCore (
                .clk(clk),
                .rstN(rstN),
                .reqValid(coreReqValid),
                .req(coreReq),
                .reqReady(coreReqReady),
                .rspValid(coreRspValid),
                .rsp(coreRsp),
                .rspReady(coreRspReady)
        );

        creditQueue #(
                .PayloadT(linkPkg::decRspT),
                .Depth(`OUT_QUEUE_DEPTH)
        ) i_outQueue (
                .clk(clk),
                .rstN(rstN),
                .pushValid(coreRspValid),
                .pushData(coreRsp),
                .full(outFull),
                .popReady(haveCredit),
                .popValid(outPending),
                .popData(outRsp)
        );

        // a slot is returned to the sender as soon as the core takes an item
        assign inCredit = coreReqValid && coreReqReady;
        assign coreRspReady = !outFull;
        assign haveCredit = sinkCredits != '0;
        assign outValid = outPending && haveCredit;

        // ****************************************
        // sink credit counter
        // ****************************************
        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        sinkCredits <= linkPkg::creditT'(`OUT_CREDITS_INIT);
                end
                else if (outCredit && !outValid)
                begin
                        sinkCredits <= sinkCredits + 1'b1;
                end
                else if (!outCredit && outValid)
                begin
                        sinkCredits <= sinkCredits - 1'b1;
                end
        end

endmodule

// ==== bench/invCipher192_properties.sv ====
`include "aes_consts.svh"

module invCipher192_properties (
        input logic            clk,
        input logic            rstN,
        input logic            inCredit,
        input logic            outValid,
        input logic            outCredit,
        input linkPkg::creditT sinkCredits
);

        int assertFails = 0;
        int portCredits;

        // credits granted by the sink and not yet spent, as seen on the ports
        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        portCredits <= `OUT_CREDITS_INIT;
                end
                else
                begin
                        portCredits <= portCredits + int'(outCredit) - int'(outValid);
                end
        end

        // an item only leaves while a sink credit is held
        noValidWithoutCredit: assert property (@(posedge clk) disable iff (!rstN)
                portCredits == 0 |-> !outValid)
        else
        begin
                assertFails++;
                $error("outValid raised with no sink credit left");
        end

        quietInReset: assert property (@(posedge clk) !rstN |-> !inCredit && !outValid)
        else
        begin
                assertFails++;
                $error("inCredit or outValid high during reset");
        end

        creditBound: assert property (@(posedge clk) disable iff (!rstN)
                sinkCredits <= `OUT_CREDITS_INIT)
        else
        begin
                assertFails++;
                $error("sink credit counter above its initial allowance");
        end

endmodule

bind invCipher192Top invCipher192_properties i_invCipher192_properties (
        .clk(clk),
        .rstN(rstN),
        .inCredit(inCredit),
        .outValid(outValid),
        .outCredit(outCredit),
        .sinkCredits(sinkCredits)
);

// ==== bench/invCipher192Tb.sv ====
`include "aes_consts.svh"

module invCipher192Tb;

        localparam int NumVec = 6;
        localparam int HoldCycles = 40;
        // per block the minimum latency plus the longest credit delay, twice over
        localparam int TimeoutCycles = NumVec * (16 + 8) * 2;

        localparam logic [`AES_KEY_BITS-1:0] FipsKey =
                192'h000102030405060708090a0b0c0d0e0f1011121314151617;
        localparam logic [`AES_BLOCK_BITS-1:0] FipsCt = 128'hdda97ca4864cdfe06eaf70a0ec0d7191;
        localparam logic [`AES_BLOCK_BITS-1:0] FipsPt = 128'h00112233445566778899aabbccddeeff;
        localparam logic [`AES_KEY_BITS-1:0] EcbKey =
                192'h8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b;
        localparam logic [`AES_BLOCK_BITS-1:0] EcbCt = 128'hbd334f1d6e45f25ff712a214571fa5cc;
        localparam logic [`AES_BLOCK_BITS-1:0] EcbPt = 128'h6bc1bee22e409f96e93d7e117393172a;

        typedef struct packed {
                linkPkg::tagT               tag;
                logic [`AES_KEY_BITS-1:0]   key;
                logic [`AES_BLOCK_BITS-1:0] cipherText;
                logic [`AES_BLOCK_BITS-1:0] plainText;
        } vectorT;

        logic            clk = 1'b0;
        logic            rstN;
        logic            inValid;
        linkPkg::decReqT inReq;
        logic            inCredit;
        logic            outValid;
        linkPkg::decRspT outRsp;
        logic            outCredit;

        vectorT      vectors [NumVec];
        logic [31:0] lfsr = 32'he904;
        int          errors = 0;
        int          cycles = 0;
        int          rxCount = 0;
        int          inCreditCount = 0;
        int          senderCredits = `IN_QUEUE_DEPTH;
        int          owed = 0;
        int          gap = 0;
        int          holdLeft = 0;
        bit          holding = 1'b1;

        invCipher192Top i_invCipher192Top (
                .clk(clk),
                .rstN(rstN),
                .inValid(inValid),
                .inReq(inReq),
                .inCredit(inCredit),
                .outValid(outValid),
                .outRsp(outRsp),
                .outCredit(outCredit)
        );

        initial
        begin
                forever
                begin
                        #10 clk = ~clk;
                end
        end

        // ****************************************
        // helpers
        // ****************************************
        function automatic logic [31:0] lfsrNext(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
        endfunction

        // three bits, one LFSR step each
        task drawDelay(output int d);
                d = 0;
                repeat (3)
                begin
                        d = (d << 1) | int'(lfsr[0]);
                        lfsr = lfsrNext(lfsr);
                end
        endtask

        task checkValue(input string name, input logic [127:0] expected,
                        input logic [127:0] actual);
                if (expected !== actual)
                begin
                        errors++;
                        $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
                end
        endtask

        task finishRun;
                int total;
                total = errors + i_invCipher192Top.i_invCipher192_properties.assertFails;
                $display("summary: %0d check errors, %0d assertion failures, %0d of %0d responses",
                         errors, total - errors, rxCount, NumVec);
                if (total == 0)
                begin
                        $display("ALL CHECKS PASSED");
                end
                else
                begin
                        $display("CHECKS FAILED");
                end
                $finish;
        endtask

        // ****************************************
        // sender
        // ****************************************
        initial
        begin
                int sent;
                vectors[0] = '{4'd0, FipsKey, FipsCt, FipsPt};
                vectors[1] = '{4'd1, EcbKey, EcbCt, EcbPt};
                vectors[2] = '{4'd2, FipsKey, FipsCt, FipsPt};
                vectors[3] = '{4'd3, EcbKey, EcbCt, EcbPt};
                vectors[4] = '{4'd4, FipsKey, FipsCt, FipsPt};
                vectors[5] = '{4'd5, EcbKey, EcbCt, EcbPt};
                rstN = 1'b0;
                inValid = 1'b0;
                inReq = '0;
                outCredit = 1'b0;
                repeat (8) @(posedge clk);
                rstN <= 1'b1;
                @(posedge clk);
                sent = 0;
                // blocks go out back to back as long as credits allow
                while (sent < NumVec)
                begin
                        if (senderCredits > 0)
                        begin
                                inValid <= 1'b1;
                                inReq <= '{tag: vectors[sent].tag,
                                           key: vectors[sent].key,
                                           cipherText: vectors[sent].cipherText};
                                senderCredits = senderCredits - 1;
                                sent++;
                        end
                        else
                        begin
                                inValid <= 1'b0;
                        end
                        @(posedge clk);
                end
                inValid <= 1'b0;
                while (rxCount < NumVec)
                begin
                        @(posedge clk);
                end
                repeat (4) @(posedge clk);
                checkValue("inCredit pulses", 128'(NumVec), 128'(inCreditCount));
                finishRun();
        end

        // outputs are settled by the falling edge
        always @(negedge clk)
        begin
                if (inCredit)
                begin
                        inCreditCount++;
                        senderCredits = senderCredits + 1;
                        if (senderCredits > `IN_QUEUE_DEPTH)
                        begin
                                errors++;
                                $display("sender holds %0d credits, more than the input queue depth",
                                         senderCredits);
                        end
                end
                if (holdLeft > 0)
                begin
                        holdLeft--;
                        if (holdLeft == 0)
                        begin
                                holding = 1'b0;
                        end
                end
                if (outValid)
                begin
                        if (rxCount >= NumVec)
                        begin
                                errors++;
                                $display("a response arrived after all %0d blocks came back", NumVec);
                        end
                        else
                        begin
                                if (holding && rxCount >= 2)
                                begin
                                        errors++;
                                        $display("outValid seen while the sink withholds every credit");
                                end
                                checkValue($sformatf("response %0d tag", rxCount),
                                           128'(vectors[rxCount].tag), 128'(outRsp.tag));
                                checkValue($sformatf("response %0d plaintext", rxCount),
                                           vectors[rxCount].plainText, outRsp.plainText);
                                rxCount++;
                                owed++;
                                if (rxCount == 2)
                                begin
                                        holdLeft = HoldCycles;
                                end
                        end
                end
        end

        // sink returns one credit per response, spaced by random gaps
        always @(posedge clk)
        begin
                if (holding)
                begin
                        outCredit <= 1'b0;
                end
                else if (gap > 0)
                begin
                        gap--;
                        outCredit <= 1'b0;
                end
                else if (owed > 0)
                begin
                        outCredit <= 1'b1;
                        owed--;
                        drawDelay(gap);
                end
                else
                begin
                        outCredit <= 1'b0;
                end
        end

        always @(posedge clk)
        begin
                cycles++;
                if (cycles >= TimeoutCycles)
                begin
                        errors++;
                        $display("timeout after %0d cycles with %0d of %0d responses received",
                                 cycles, rxCount, NumVec);
                        finishRun();
                end
        end

endmodule

// ==== sources.f ====
+incdir+design
design/aesPkg.sv
design/linkPkg.sv
design/byteSubst.sv
design/keyExpand192.sv
design/invCipherCore.sv
design/creditQueue.sv
design/invCipher192Top.sv
bench/invCipher192_properties.sv
bench/invCipher192Tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module invCipher192Tb --Mdir obj_dir -o simv

run: compile
	./obj_dir/simv +verilator+error+limit+100 | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
